/* nibble_cpu_pkg.sv */
package nibble_cpu_pkg;

    localparam int xlen      = 32;              // word width
    localparam int nibbles   = 8;               // nibble steps per word
    localparam int mem_words = 1024;            // ram depth in words
    localparam logic [xlen-1:0] start_addr = 32'h0000_0100; // reset pc

    // major opcodes, values straight from the rv32i encoding
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011
    } opcode_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,                                // b inverted, carry seeded with one
        alu_and,
        alu_xor
    } alu_op_e;

    typedef struct packed {
        opcode_e         opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      funct3;
        logic            funct7_5;              // sub vs add
        logic [xlen-1:0] imm;                   // already sign extended
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0] addr;                  // byte address, word aligned
        logic [xlen-1:0] wdata;
        logic            we;
        logic            re;
    } mem_req_t;

    typedef struct packed {
        logic [xlen-1:0] pc;                    // pc of the retiring instr
        logic [4:0]      rd;
        logic [xlen-1:0] value;                 // value written to rd
        logic            we;
    } retire_t;

endpackage

/* nibble_alu.sv */
`timescale 1ns/1ns
module nibble_alu (
    input  logic [3:0]              a,
    input  logic [3:0]              b,
    input  logic                    carry_in,
    input  nibble_cpu_pkg::alu_op_e op,
    output logic [3:0]              result,
    output logic                    carry_out
);

    logic [4:0] carry;                          // ripple chain with carry in at bit 0
    logic [3:0] sum;

    assign carry[0] = carry_in;

    for (genvar i = 0; i < 4; i++) begin : g_full_adder
        assign sum[i]     = a[i] ^ b[i] ^ carry[i];
        assign carry[i+1] = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
    end

    assign carry_out = carry[4];                // only meaningful for add/sub

    always_comb begin
        case (op)
            nibble_cpu_pkg::alu_add,
            nibble_cpu_pkg::alu_sub: result = sum;   // sub arrives with b inverted
            nibble_cpu_pkg::alu_and: result = a & b;
            default:                 result = a ^ b;
        endcase
    end

endmodule

/* nibble_sequencer.sv */
`timescale 1ns/1ns
module nibble_sequencer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [nibble_cpu_pkg::xlen-1:0] a,
    input  logic [nibble_cpu_pkg::xlen-1:0] b,
    input  nibble_cpu_pkg::alu_op_e         op,
    output logic [nibble_cpu_pkg::xlen-1:0] result,
    output logic                            zero,
    output logic                            done,
    output logic [3:0]                      nibble_a,
    output logic [3:0]                      nibble_b,
    output logic                            carry_in,
    output nibble_cpu_pkg::alu_op_e         nibble_op,
    input  logic [3:0]                      nibble_res,
    input  logic                            carry_out
);

    logic [nibble_cpu_pkg::xlen-1:0] a_sh;      // operand a with low nibble next
    logic [nibble_cpu_pkg::xlen-1:0] b_sh;      // operand b inverted for sub
    logic [nibble_cpu_pkg::xlen-1:0] res_sh;    // result fills from the top
    logic [nibble_cpu_pkg::xlen-1:0] cur_a;
    logic [nibble_cpu_pkg::xlen-1:0] cur_b;
    logic [$clog2(nibble_cpu_pkg::nibbles)-1:0] step;
    logic                            carry;
    logic                            busy;
    logic                            active;
    nibble_cpu_pkg::alu_op_e         op_q;

    // nibble 0 is handled in the start cycle straight from the inputs
    assign active    = busy || start;           // start while busy is ignored
    assign cur_a     = busy ? a_sh : a;
    assign cur_b     = busy ? b_sh : ((op == nibble_cpu_pkg::alu_sub) ? ~b : b);
    assign nibble_a  = cur_a[3:0];
    assign nibble_b  = cur_b[3:0];
    assign carry_in  = busy ? carry : (op == nibble_cpu_pkg::alu_sub); // +1 for two's compl
    assign nibble_op = busy ? op_q : op;
    assign result    = res_sh;
    assign zero      = (res_sh == '0);          // beq compare

    always_ff @(posedge clk) begin
        if (active) begin
            a_sh   <= cur_a >> 4;
            b_sh   <= cur_b >> 4;
            res_sh <= {nibble_res, res_sh[nibble_cpu_pkg::xlen-1:4]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            step  <= '0;
            carry <= 1'b0;
            done  <= 1'b0;
            op_q  <= nibble_cpu_pkg::alu_add;
        end else begin
            done <= busy && (step == 3'(nibble_cpu_pkg::nibbles - 1)); // 8 cycles after start
            if (active)
                carry <= carry_out;             // chained into the next nibble
            if (start && !busy) begin
                busy <= 1'b1;
                step <= 3'd1;
                op_q <= op;
            end else if (busy) begin
                step <= step + 3'd1;
                if (step == 3'(nibble_cpu_pkg::nibbles - 1))
                    busy <= 1'b0;
            end
        end
    end

    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start && !busy, nibble_cpu_pkg::nibbles))
        else $error("done not eight cycles after an accepted start");

endmodule

/* register_file.sv */
`timescale 1ns/1ns
module register_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [4:0]                      rs1_addr,
    input  logic [4:0]                      rs2_addr,
    output logic [nibble_cpu_pkg::xlen-1:0] rs1_data,
    output logic [nibble_cpu_pkg::xlen-1:0] rs2_data,
    input  logic [4:0]                      rd_addr,
    input  logic [nibble_cpu_pkg::xlen-1:0] rd_data,
    input  logic                            rd_we
);

    logic [nibble_cpu_pkg::xlen-1:0] regs [32]; // x0 cleared by reset and never written

    assign rs1_data = regs[rs1_addr];           // comb read
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (rd_we && (rd_addr != 5'd0)) begin // writes to x0 dropped
            regs[rd_addr] <= rd_data;
        end
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs1_addr == 5'd0) |-> (rs1_data == '0)) and ((rs2_addr == 5'd0) |-> (rs2_data == '0)))
        else $error("x0 read non-zero");

endmodule

/* ram.sv */
`timescale 1ns/1ns
module ram (
    input  logic                            clk,
    input  nibble_cpu_pkg::mem_req_t        req,
    output logic [nibble_cpu_pkg::xlen-1:0] rdata,
    input  logic                            load_en,
    input  logic [nibble_cpu_pkg::xlen-1:0] load_addr,
    input  logic [nibble_cpu_pkg::xlen-1:0] load_data
);

    logic [nibble_cpu_pkg::xlen-1:0] mem [nibble_cpu_pkg::mem_words];
    logic [$clog2(nibble_cpu_pkg::mem_words)-1:0] core_idx;
    logic [$clog2(nibble_cpu_pkg::mem_words)-1:0] load_idx;

    // byte address to word index, bits 11..2
    assign core_idx = req.addr[$clog2(nibble_cpu_pkg::mem_words)+1:2];
    assign load_idx = load_addr[$clog2(nibble_cpu_pkg::mem_words)+1:2];

    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_idx] <= load_data;         // program load beats the core
        else if (req.we)
            mem[core_idx] <= req.wdata;
        if (req.re)
            rdata <= mem[core_idx];             // one cycle latency
    end

    a_no_rw: assert property (@(posedge clk) !(req.we && req.re))
        else $error("read and write in one request");

endmodule

/* control.sv */
`timescale 1ns/1ns
module control (
    input  logic                            clk,
    input  logic                            rst_n,
    output nibble_cpu_pkg::mem_req_t        mem_req,
    input  logic [nibble_cpu_pkg::xlen-1:0] mem_rdata,
    output logic [4:0]                      rs1_addr,
    output logic [4:0]                      rs2_addr,
    input  logic [nibble_cpu_pkg::xlen-1:0] rs1_data,
    input  logic [nibble_cpu_pkg::xlen-1:0] rs2_data,
    output logic [4:0]                      rd_addr,
    output logic [nibble_cpu_pkg::xlen-1:0] rd_data,
    output logic                            rd_we,
    output logic                            alu_start,
    output logic [nibble_cpu_pkg::xlen-1:0] alu_a,
    output logic [nibble_cpu_pkg::xlen-1:0] alu_b,
    output nibble_cpu_pkg::alu_op_e         alu_op,
    input  logic [nibble_cpu_pkg::xlen-1:0] alu_result,
    input  logic                            alu_zero,
    input  logic                            alu_done,
    output nibble_cpu_pkg::retire_t         retire,
    output logic                            retire_valid,
    output logic                            store_valid,
    output logic                            error
);

    typedef enum logic [2:0] {
        st_fetch, st_fetch_wait, st_decode, st_execute, st_memory, st_writeback, st_error
    } state_e;

    state_e                          state;
    nibble_cpu_pkg::decoded_t        dec;
    logic [nibble_cpu_pkg::xlen-1:0] pc;
    logic [nibble_cpu_pkg::xlen-1:0] ir;
    logic [nibble_cpu_pkg::xlen-1:0] res_q;     // last sequencer result
    logic [nibble_cpu_pkg::xlen-1:0] pc_plus4;
    logic [nibble_cpu_pkg::xlen-1:0] next_pc;
    logic [nibble_cpu_pkg::xlen-1:0] wb_value;
    logic                            known;
    logic                            uses_alu;
    logic                            writes_rd;
    logic                            pass2;     // beq second run computes target, taken only
    logic                            relaunch;
    logic                            alu_pending;

    always_comb begin
        dec.opcode   = nibble_cpu_pkg::opcode_e'(ir[6:0]);
        dec.rd       = ir[11:7];
        dec.rs1      = ir[19:15];
        dec.rs2      = ir[24:20];
        dec.funct3   = ir[14:12];
        dec.funct7_5 = ir[30];
        case (dec.opcode)
            nibble_cpu_pkg::store:  dec.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            nibble_cpu_pkg::branch: dec.imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            nibble_cpu_pkg::lui,
            nibble_cpu_pkg::auipc:  dec.imm = {ir[31:12], 12'b0};
            nibble_cpu_pkg::jal:    dec.imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            default:                dec.imm = {{20{ir[31]}}, ir[31:20]};      // I type
        endcase
        case (dec.opcode)
            nibble_cpu_pkg::op_imm, nibble_cpu_pkg::op, nibble_cpu_pkg::load,
            nibble_cpu_pkg::store, nibble_cpu_pkg::lui, nibble_cpu_pkg::auipc,
            nibble_cpu_pkg::jal, nibble_cpu_pkg::jalr, nibble_cpu_pkg::branch: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    assign uses_alu  = known && (dec.opcode != nibble_cpu_pkg::lui)
                             && (dec.opcode != nibble_cpu_pkg::jal);
    assign writes_rd = known && (dec.opcode != nibble_cpu_pkg::store)
                             && (dec.opcode != nibble_cpu_pkg::branch);
    assign relaunch  = (state == st_execute) && alu_done && alu_zero && !pass2
                       && (dec.opcode == nibble_cpu_pkg::branch);  // beq taken
    assign alu_start = ((state == st_decode) && uses_alu) || relaunch;

    always_comb begin
        alu_a  = rs1_data;
        alu_b  = dec.imm;
        alu_op = nibble_cpu_pkg::alu_add;       // address arithmetic default
        if (relaunch) begin
            alu_a = pc;                         // branch target pc+imm
        end else begin
            case (dec.opcode)
                nibble_cpu_pkg::op_imm, nibble_cpu_pkg::op: begin
                    if (dec.opcode == nibble_cpu_pkg::op)
                        alu_b = rs2_data;
                    if (dec.funct3 == 3'b111)
                        alu_op = nibble_cpu_pkg::alu_and;
                    else if (dec.funct3 == 3'b100)
                        alu_op = nibble_cpu_pkg::alu_xor;
                    else if (dec.opcode == nibble_cpu_pkg::op && dec.funct7_5)
                        alu_op = nibble_cpu_pkg::alu_sub;
                end
                nibble_cpu_pkg::auipc: alu_a = pc;
                nibble_cpu_pkg::branch: begin
                    alu_b  = rs2_data;
                    alu_op = nibble_cpu_pkg::alu_sub;  // zero flag means equal
                end
                default: ;
            endcase
        end
    end

    assign pc_plus4 = pc + 32'd4;               // link value without alu

    always_comb begin
        case (dec.opcode)
            nibble_cpu_pkg::jal:    next_pc = pc + dec.imm;
            nibble_cpu_pkg::jalr:   next_pc = {res_q[nibble_cpu_pkg::xlen-1:1], 1'b0};
            nibble_cpu_pkg::branch: next_pc = pass2 ? res_q : pc_plus4;
            default:                next_pc = pc_plus4;
        endcase
        case (dec.opcode)
            nibble_cpu_pkg::lui:    wb_value = dec.imm;
            nibble_cpu_pkg::jal,
            nibble_cpu_pkg::jalr:   wb_value = pc_plus4;
            nibble_cpu_pkg::load:   wb_value = mem_rdata;   // read issued in st_memory
            default:                wb_value = res_q;
        endcase
    end

    always_comb begin
        mem_req = '0;
        case (state)
            st_fetch: begin
                mem_req.addr = pc;
                mem_req.re   = 1'b1;
            end
            st_memory: begin
                mem_req.addr = res_q;           // rs1+imm from the sequencer
                mem_req.re   = 1'b1;
            end
            st_writeback: begin
                mem_req.addr  = res_q;
                mem_req.wdata = rs2_data;
                mem_req.we    = (dec.opcode == nibble_cpu_pkg::store);
            end
            default: ;
        endcase
    end

    assign rs1_addr     = dec.rs1;
    assign rs2_addr     = dec.rs2;
    assign rd_addr      = dec.rd;
    assign rd_data      = wb_value;
    assign rd_we        = (state == st_writeback) && writes_rd;
    assign retire       = '{pc: pc, rd: dec.rd, value: wb_value, we: writes_rd};
    assign retire_valid = (state == st_writeback);
    assign store_valid  = (state == st_writeback) && (dec.opcode == nibble_cpu_pkg::store);
    assign error        = (state == st_error);

    always_ff @(posedge clk) begin
        if (state == st_fetch_wait)
            ir <= mem_rdata;                    // instruction word
        if ((state == st_execute) && alu_done)
            res_q <= alu_result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_fetch;
            pc          <= nibble_cpu_pkg::start_addr;
            pass2       <= 1'b0;
            alu_pending <= 1'b0;
        end else begin
            if (alu_start)
                alu_pending <= 1'b1;
            else if (alu_done)
                alu_pending <= 1'b0;
            case (state)
                st_fetch:      state <= st_fetch_wait;
                st_fetch_wait: state <= st_decode;
                st_decode: begin
                    if (!known)
                        state <= st_error;      // sticky until reset
                    else
                        state <= uses_alu ? st_execute : st_writeback;
                end
                st_execute: begin
                    if (relaunch) begin
                        pass2 <= 1'b1;
                    end else if (alu_done) begin
                        state <= (dec.opcode == nibble_cpu_pkg::load) ? st_memory
                                                                      : st_writeback;
                    end
                end
                st_memory:     state <= st_writeback;
                st_writeback: begin
                    pc    <= next_pc;
                    pass2 <= 1'b0;
                    state <= st_fetch;
                end
                default:       state <= st_error;
            endcase
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        alu_start |-> (!alu_pending || alu_done))
        else $error("alu_start while sequencer busy");

    a_mem_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.we || mem_req.re) |-> (mem_req.addr[1:0] == 2'b00))
        else $error("memory request at a misaligned address");

endmodule

/* cpu_top.sv */
`timescale 1ns/1ns
module cpu_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_en,
    input  logic [nibble_cpu_pkg::xlen-1:0] load_addr,
    input  logic [nibble_cpu_pkg::xlen-1:0] load_data,
    output nibble_cpu_pkg::retire_t         retire,
    output logic                            retire_valid,
    output logic                            store_valid,
    output nibble_cpu_pkg::mem_req_t        store,     // core memory request, valid with store_valid
    output logic                            error
);

    logic [4:0]                      rs1_addr;
    logic [4:0]                      rs2_addr;
    logic [4:0]                      rd_addr;
    logic [nibble_cpu_pkg::xlen-1:0] rs1_data;
    logic [nibble_cpu_pkg::xlen-1:0] rs2_data;
    logic [nibble_cpu_pkg::xlen-1:0] rd_data;
    logic [nibble_cpu_pkg::xlen-1:0] mem_rdata;
    logic [nibble_cpu_pkg::xlen-1:0] alu_a;
    logic [nibble_cpu_pkg::xlen-1:0] alu_b;
    logic [nibble_cpu_pkg::xlen-1:0] alu_result;
    logic                            rd_we;
    logic                            alu_start;
    logic                            alu_zero;
    logic                            alu_done;
    logic                            carry_in;
    logic                            carry_out;
    logic [3:0]                      nibble_a;
    logic [3:0]                      nibble_b;
    logic [3:0]                      nibble_res;
    nibble_cpu_pkg::alu_op_e         alu_op;
    nibble_cpu_pkg::alu_op_e         nibble_op;

    control control_inst (
        .clk, .rst_n, .mem_req(store), .mem_rdata, .rs1_addr, .rs2_addr, .rs1_data,
        .rs2_data, .rd_addr, .rd_data, .rd_we, .alu_start, .alu_a, .alu_b, .alu_op,
        .alu_result, .alu_zero, .alu_done, .retire, .retire_valid, .store_valid, .error
    );

    nibble_sequencer nibble_sequencer_inst (
        .clk, .rst_n, .start(alu_start), .a(alu_a), .b(alu_b), .op(alu_op),
        .result(alu_result), .zero(alu_zero), .done(alu_done), .nibble_a, .nibble_b,
        .carry_in, .nibble_op, .nibble_res, .carry_out
    );

    nibble_alu nibble_alu_inst (
        .a(nibble_a), .b(nibble_b), .carry_in, .op(nibble_op),
        .result(nibble_res), .carry_out
    );

    register_file register_file_inst (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .rd_addr, .rd_data, .rd_we
    );

    ram ram_inst (
        .clk, .req(store), .rdata(mem_rdata), .load_en, .load_addr, .load_data
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns
module tb_clock (
    output logic clk
);

    initial clk = 1'b0;                         // first rising edge at 20 ns

    always #20 clk = ~clk;                      // 40 ns period

endmodule

/* cpu_tb.sv */
`timescale 1ns/1ns
module cpu_tb;

    logic                     clk;
    logic                     rst_n;
    logic                     load_en;
    logic [31:0]              load_addr;
    logic [31:0]              load_data;
    nibble_cpu_pkg::retire_t  retire;
    logic                     retire_valid;
    logic                     store_valid;
    nibble_cpu_pkg::mem_req_t store;
    logic                     error;

    logic [31:0] prog_words [64];               // image from start_addr upward
    int          prog_len = 0;
    logic        program_ready = 1'b0;
    logic [15:0] lfsr_state = 16'd54232;
    int          retire_errors = 0;
    int          store_errors = 0;
    int          control_errors = 0;

    logic [31:0] model_regs [32];               // architectural state by rv32i rules
    logic [31:0] model_mem [nibble_cpu_pkg::mem_words];
    logic [31:0] model_pc;
    logic [31:0] instr;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] ea;                            // rs1 + i-type imm
    logic [31:0] exp_value;
    logic [31:0] exp_next_pc;
    logic [31:0] exp_store_addr;
    logic [31:0] exp_store_data;
    logic [4:0]  exp_rd;
    logic        exp_we;
    logic        exp_store;
    logic        exp_known;

    tb_clock tb_clock_inst (.clk);

    cpu_top cpu_top_inst (
        .clk, .rst_n, .load_en, .load_addr, .load_data, .retire, .retire_valid,
        .store_valid, .store, .error
    );

    // fibonacci lfsr x^16+x^14+x^13+x^11+1 stepped once per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000, rd, opc};     // funct3 0 for addi and jalr
    endfunction

    function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011}; // beq
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog_words[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        logic [11:0] r1;
        logic [11:0] r2;
        r1 = 12'(random_bits(12));
        r2 = 12'(random_bits(12));
        emit(i_type(r1, 5'd0, 5'd1, 7'b0010011));          // 0x100 addi x1, x0, r1
        emit(i_type(r2, 5'd1, 5'd2, 7'b0010011));          // addi x2, x1, r2
        emit(r_type(3'b000, 5'd3, 5'd1, 5'd2));            // add x3, x1, x2
        emit(i_type(12'hffb, 5'd3, 5'd4, 7'b0010011));     // addi x4, x3, -5
        emit(r_type(3'b111, 5'd5, 5'd3, 5'd4));            // and x5, x3, x4
        emit(i_type(12'd7, 5'd1, 5'd0, 7'b0010011));       // addi x0, x1, 7
        emit(r_type(3'b000, 5'd6, 5'd0, 5'd1));            // add x6, x0, x1
        emit(u_type(20'h00001, 5'd8, 7'b0110111));         // lui x8 -> 0x1000
        emit(s_type(12'hff0, 5'd3, 5'd8));                 // sw x3, -16(x8)
        emit(i_type(12'hff0, 5'd8, 5'd9, 7'b0000011) | 32'h2000); // lw x9, -16(x8)
        emit(u_type(20'h12345, 5'd10, 7'b0010111));        // 0x128 auipc x10
        emit(u_type(20'habcde, 5'd11, 7'b0110111));        // lui x11 with negative upper part
        emit(j_type(21'd8, 5'd12));                        // 0x130 jal x12, +8
        emit(i_type(12'd1, 5'd0, 5'd13, 7'b0010011));      // skipped
        emit(u_type(20'h0, 5'd14, 7'b0010111));            // 0x138 auipc x14, 0
        emit(i_type(12'd12, 5'd14, 5'd15, 7'b1100111));    // jalr x15, 12(x14) -> 0x144
        emit(i_type(12'd2, 5'd0, 5'd13, 7'b0010011));      // skipped
        emit(b_type(13'd8, 5'd1, 5'd1));                   // 0x144 beq taken
        emit(i_type(12'd3, 5'd0, 5'd13, 7'b0010011));      // skipped
        emit(b_type(13'd8, 5'd8, 5'd1));                   // not taken as x1 is never 0x1000
        emit(i_type(12'hfff, 5'd9, 5'd16, 7'b0010011));    // addi x16, x9, -1
        for (int i = 0; i < 4; i++)                         // random addi chain
            emit(i_type(12'(random_bits(12)), 5'(16 + i), 5'(17 + i), 7'b0010011));
        emit(32'h0000_0000);                               // unknown opcode ends the run
    endtask

    task automatic load_program();
        for (int k = 0; k < prog_len; k++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = nibble_cpu_pkg::start_addr + 32'(4 * k);
            load_data = prog_words[k];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic retire_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        retire_errors++;
        $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
    endtask

    task automatic store_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        store_errors++;
        $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
    endtask

    // next retire predicted from the model state
    always_comb begin
        instr          = model_mem[model_pc[11:2]]; // 4 KB word space
        rs1v           = model_regs[instr[19:15]];
        rs2v           = model_regs[instr[24:20]];
        ea             = rs1v + {{20{instr[31]}}, instr[31:20]};
        exp_rd         = instr[11:7];
        exp_known      = 1'b1;
        exp_we         = 1'b1;                  // cleared for sw and beq
        exp_store      = 1'b0;
        exp_value      = '0;
        exp_next_pc    = model_pc + 32'd4;
        exp_store_addr = rs1v + {{20{instr[31]}}, instr[31:25], instr[11:7]};
        exp_store_data = rs2v;
        case (instr[6:0])
            7'b0010011: exp_value = ea;         // addi
            7'b0110011: exp_value = (instr[14:12] == 3'b111) ? (rs1v & rs2v) : (rs1v + rs2v);
            7'b0000011: exp_value = model_mem[ea[11:2]]; // lw
            7'b0100011: begin                   // sw
                exp_we    = 1'b0;
                exp_store = 1'b1;
            end
            7'b0110111: exp_value = {instr[31:12], 12'b0};
            7'b0010111: exp_value = model_pc + {instr[31:12], 12'b0};
            7'b1101111: begin                   // jal
                exp_value   = model_pc + 32'd4;
                exp_next_pc = model_pc + {{12{instr[31]}}, instr[19:12], instr[20],
                                          instr[30:21], 1'b0};
            end
            7'b1100111: begin                   // jalr clears the lsb
                exp_value   = model_pc + 32'd4;
                exp_next_pc = {ea[31:1], 1'b0};
            end
            7'b1100011: begin                   // beq
                exp_we = 1'b0;
                if (rs1v == rs2v)
                    exp_next_pc = model_pc + {{20{instr[31]}}, instr[7], instr[30:25],
                                              instr[11:8], 1'b0};
            end
            default: exp_known = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            model_pc <= nibble_cpu_pkg::start_addr;
            for (int r = 0; r < 32; r++)
                model_regs[r] <= '0;
            for (int k = 0; k < prog_len; k++)
                model_mem[nibble_cpu_pkg::start_addr[11:2] + k] <= prog_words[k];
        end else if (retire_valid) begin
            if (exp_we && (exp_rd != 5'd0))
                model_regs[exp_rd] <= exp_value; // x0 stays zero
            if (exp_store)
                model_mem[exp_store_addr[11:2]] <= exp_store_data;
            model_pc <= exp_next_pc;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!retire_valid && !store_valid && !error))
        else begin
            control_errors++;
            $display("%0t retire, store or error was active while in reset", $time);
        end

    a_retire_pc: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (retire.pc == model_pc))
        else retire_mismatch("retire.pc", $sampled(retire.pc), $sampled(model_pc));

    a_retire_we: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (retire.we == exp_we))
        else retire_mismatch("retire.we", 32'($sampled(retire.we)), 32'($sampled(exp_we)));

    a_retire_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && exp_we) |-> (retire.rd == exp_rd))
        else retire_mismatch("retire.rd", 32'($sampled(retire.rd)), 32'($sampled(exp_rd)));

    a_retire_value: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && exp_we) |-> (retire.value == exp_value))
        else retire_mismatch("retire.value", $sampled(retire.value), $sampled(exp_value));

    a_store_valid: assert property (@(posedge clk) disable iff (!rst_n)
        store_valid == (retire_valid && exp_store))
        else store_mismatch("store_valid", 32'($sampled(store_valid)),
                            32'($sampled(retire_valid && exp_store)));

    a_store_we: assert property (@(posedge clk) disable iff (!rst_n)
        store.we == (retire_valid && exp_store))
        else store_mismatch("store.we", 32'($sampled(store.we)),
                            32'($sampled(retire_valid && exp_store)));

    a_store_re: assert property (@(posedge clk) disable iff (!rst_n)
        store_valid |-> !store.re)
        else store_mismatch("store.re", 32'($sampled(store.re)), 32'(0));

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        store_valid |-> (store.addr == exp_store_addr))
        else store_mismatch("store.addr", $sampled(store.addr), $sampled(exp_store_addr));

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        store_valid |-> (store.wdata == exp_store_data))
        else store_mismatch("store.wdata", $sampled(store.wdata), $sampled(exp_store_data));

    a_no_bad_retire: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (exp_known && !error))
        else begin
            control_errors++;
            $display("%0t an instruction retired at an unknown opcode or after error", $time);
        end

    a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        error |-> (!exp_known ##1 error))
        else begin
            control_errors++;
            $display("%0t error came at a known opcode or did not stay high", $time);
        end

    initial begin
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_program();
        program_ready = 1'b1;
        fork
            begin
                repeat (5) @(negedge clk);
                rst_n = 1'b1;
            end
            load_program();                     // one word per cycle ahead of fetch
        join
        wait (error);
        repeat (10) @(negedge clk);             // error holds and nothing retires
        $display("errors: retire %0d store %0d control %0d",
                 retire_errors, store_errors, control_errors);
        if ((retire_errors + store_errors + control_errors) == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // 40 cycles per instruction plus reset and slack
    initial begin
        wait (program_ready);
        #((5 + 20 + 40 * prog_len) * 40);
        $display("watchdog expired before the core reached the error state");
        $display("Checks failed");
        $finish;
    end

endmodule

/* sources.f */
nibble_cpu_pkg.sv
nibble_alu.sv
nibble_sequencer.sv
register_file.sv
ram.sv
control.sv
cpu_top.sv
tb_clock.sv
cpu_tb.sv
